/* list.f */
hw/cam_bist_pkg.sv
hw/cam_port_if.sv
hw/cam_array.sv
hw/cam_bist_regs.sv
hw/cam_bist_engine.sv
hw/cam_bist_outhandler.sv
hw/cam_bist_top.sv
tests/cam_bist_assertions.sv
tests/tb_cam_bist.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CAM BIST testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -f list.f --top-module tb_cam_bist -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cam_bist +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

/* tests/cam_bist_vectors.txt */
// Fields in hex: match_sel cm_mode background stall_percent
// match_sel 0 all match, 1 single match, 2 single mismatch, 3 all mismatch
00 01 a5 00
01 01 3c 1e
02 01 5a 32
03 01 c3 46
00 00 96 14
01 00 7e 28
02 00 e1 3c
03 00 0f 0a
02 01 ff 50
01 01 00 28
01 00 b4 50
03 01 69 00
00 00 00 32
02 00 5a 46

/* tests/tb_cam_bist.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cam_bist;

  localparam int clk_period   = 40;
  localparam int max_tests    = 32;
  // Cycles allowed between two results, covers heavy stalls
  localparam int result_bound = 200;
  // Config, fill and drain overhead per test in cycles
  localparam int test_setup   = 100;

  logic        bist_clk;
  logic        rst_n;
  logic        cfg_valid;
  logic        cfg_ready;
  logic [15:0] cfg_word;
  logic        res_valid;
  logic        res_ready;
  logic [3:0]  res_addr;
  logic [7:0]  res_data;
  logic        busy;

  // Four fields per test, 8'hff in the first field ends the list
  logic [7:0] vec [4*max_tests];
  int         ntests;
  logic       loaded;
  int         errors;
  int         checks;
  int         failed_tests;

  cam_bist_top dut (
    .bist_clk  (bist_clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cfg_word  (cfg_word),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_addr  (res_addr),
    .res_data  (res_data),
    .busy      (busy)
  );

  initial begin
    bist_clk = 1'b0;
    forever begin
      #(clk_period / 2) bist_clk = ~bist_clk;
    end
  end

  // ==========================================================================
  // Reference model and host port
  // ==========================================================================

  // Compare runs on a fault-free array give zero, reads give the fill value
  function automatic logic [7:0] expected_result(input logic [1:0] sel, input logic cm,
                                                 input logic [7:0] bg, input logic [3:0] a);
    if (cm) begin
      return 8'h00;
    end
    // Single match fill is upper background nibble joined to the address
    if (sel == 2'b01) begin
      return {bg[7:4], a};
    end
    return bg;
  endfunction

  // Offer one word and hold it until the handshake edge
  task automatic send_word(input logic [15:0] w);
    int waited;
    waited = 0;
    @(posedge bist_clk);
    cfg_valid <= 1'b1;
    cfg_word  <= w;
    @(negedge bist_clk);
    while (!cfg_ready && waited < 20) begin
      waited++;
      @(negedge bist_clk);
    end
    if (!cfg_ready) begin
      $display("time %0t: configuration word %h was never accepted", $time, w);
      errors++;
    end
    @(posedge bist_clk);
    cfg_valid <= 1'b0;
  endtask

  // ==========================================================================
  // One BIST run
  // ==========================================================================

  task automatic run_test(input int t);
    logic [1:0] sel;
    logic       cm;
    logic [7:0] bg;
    logic [7:0] exp_data;
    int         stall;
    int         got;
    int         idle;
    int         err_before;
    sel        = vec[4*t][1:0];
    cm         = vec[4*t+1][0];
    bg         = vec[4*t+2];
    stall      = int'(vec[4*t+3]);
    got        = 0;
    idle       = 0;
    err_before = errors;

    // Background first, then control with start
    send_word({2'b01, 6'b0, bg});
    send_word({2'b00, 1'b1, cm, sel, 10'b0});

    // start_pulse comes first, busy one edge later
    @(negedge bist_clk);
    while (!busy && idle < 8) begin
      idle++;
      @(negedge bist_clk);
    end
    if (!busy) begin
      $display("time %0t: busy never rose after start", $time);
      errors++;
    end
    idle = 0;

    // Drain with random stalls, harmless background word held on the host port
    while (got < 16 && idle < result_bound) begin
      @(posedge bist_clk);
      res_ready <= (($urandom % 100) >= stall);
      cfg_valid <= 1'b1;
      cfg_word  <= {2'b01, 6'b0, bg};
      @(negedge bist_clk);
      checks++;
      if (busy && cfg_ready) begin
        $display("time %0t: configuration port ready during a run", $time);
        errors++;
      end
      if (res_valid && res_ready) begin
        exp_data = expected_result(sel, cm, bg, 4'(got));
        checks += 3;
        if (res_addr != 4'(got)) begin
          $display("mismatch at time %0t: res_addr expected %0d actual %0d",
                   $time, got, res_addr);
          errors++;
        end
        if (res_data != exp_data) begin
          $display("mismatch at time %0t: res_data expected %h actual %h",
                   $time, exp_data, res_data);
          errors++;
        end
        if (!busy) begin
          $display("time %0t: busy low before result %0d was taken", $time, got);
          errors++;
        end
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got < 16) begin
      $display("time %0t: only %0d of 16 results arrived", $time, got);
      errors++;
    end

    // Last handshake edge, then busy must drop with nothing left queued
    @(posedge bist_clk);
    res_ready <= 1'b0;
    idle = 0;
    @(negedge bist_clk);
    while (busy && idle < 8) begin
      idle++;
      @(negedge bist_clk);
    end
    checks += 2;
    if (busy) begin
      $display("time %0t: busy still high after the last result", $time);
      errors++;
    end
    if (res_valid) begin
      $display("time %0t: extra result after the run", $time);
      errors++;
    end
    // Held background word transfers here, same value as before
    @(posedge bist_clk);
    cfg_valid <= 1'b0;

    if (errors != err_before) begin
      failed_tests++;
    end
    $display("test %0d algo %0d mode %0d bg %h stall %0d: %s", t, sel, cm, bg, stall,
             (errors == err_before) ? "pass" : "fail");
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    int seed_val;
    rst_n        = 1'b0;
    cfg_valid    = 1'b0;
    cfg_word     = 16'h0000;
    res_ready    = 1'b0;
    errors       = 0;
    checks       = 0;
    failed_tests = 0;
    ntests       = 0;
    loaded       = 1'b0;
    seed_val     = $urandom(32'h34ed);

    for (int i = 0; i < 4 * max_tests; i++) begin
      vec[i] = 8'hff;
    end
    $readmemh("tests/cam_bist_vectors.txt", vec);
    while (ntests < max_tests && vec[4*ntests] != 8'hff) begin
      ntests++;
    end
    loaded = 1'b1;
    if (ntests == 0) begin
      $display("no test vectors were read");
      errors++;
    end

    repeat (8) @(posedge bist_clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge bist_clk);

    for (int t = 0; t < ntests; t++) begin
      run_test(t);
    end
    repeat (2) @(posedge bist_clk);

    errors += dut.u_checks.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             ntests, failed_tests, checks, errors, dut.u_checks.fail_count);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Bound from test count, results per test and per-result stall allowance
  initial begin
    wait (loaded);
    #((ntests * 16 * result_bound + ntests * test_setup + 100) * clk_period);
    $display("watchdog expired at %0t, run did not finish", $time);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/cam_bist_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_assertions #(
  parameter int dwidth = 8
) (
  input wire logic              bist_clk,
  input wire logic              rst_n,
  input wire logic              cfg_ready,
  input wire logic              busy,
  input wire logic              res_valid,
  input wire logic              res_ready,
  input wire logic [3:0]        res_addr,
  input wire logic [dwidth-1:0] res_data
);

  // Failure count, read back by the testbench
  int fail_count = 0;

  // A stalled result holds until it is taken
  stalled_result_stable: assert property (
    @(posedge bist_clk) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res_addr) && $stable(res_data)
  ) else begin
    $error("result changed or dropped while the stream was stalled");
    fail_count++;
  end

  // Host port closed during a run
  cfg_closed_while_busy: assert property (
    @(posedge bist_clk) disable iff (!rst_n)
    busy |-> !cfg_ready
  ) else begin
    $error("configuration port ready while busy");
    fail_count++;
  end

  // Empty result FIFO right out of reset
  no_result_after_reset: assert property (
    @(posedge bist_clk)
    $rose(rst_n) |-> !res_valid
  ) else begin
    $error("result valid in the first cycle after reset");
    fail_count++;
  end

endmodule

bind cam_bist_top cam_bist_assertions #(.dwidth(dwidth)) u_checks (
  .bist_clk  (bist_clk),
  .rst_n     (rst_n),
  .cfg_ready (cfg_ready),
  .busy      (busy),
  .res_valid (res_valid),
  .res_ready (res_ready),
  .res_addr  (res_addr),
  .res_data  (res_data)
);

`default_nettype wire

/* hw/cam_bist_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_top #(
  parameter int entries = cam_bist_pkg::cam_entries,
  parameter int dwidth  = cam_bist_pkg::cam_dwidth
) (
  input  wire logic                                bist_clk,
  input  wire logic                                rst_n,
  // Host configuration port
  input  wire logic                                cfg_valid,
  output logic                                     cfg_ready,
  input  wire logic [15:0]                         cfg_word,
  // Result stream
  output logic                                     res_valid,
  input  wire logic                                res_ready,
  output logic [cam_bist_pkg::cam_awidth-1:0]      res_addr,
  output logic [dwidth-1:0]                        res_data,
  // Run status
  output logic                                     busy
);

  // Configuration from regs to engine and output handler
  logic                     start_pulse;
  cam_bist_pkg::match_sel_t match_sel;
  logic                     cm_mode;
  logic [dwidth-1:0]        background;

  // CAM ports
  cam_port_if #(.entries(entries), .dwidth(dwidth)) cam_bus ();

  cam_bist_regs #(.dwidth(dwidth)) u_regs (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .cfg_valid   (cfg_valid),
    .cfg_ready   (cfg_ready),
    .cfg_word    (cfg_word),
    .busy        (busy),
    .start_pulse (start_pulse),
    .match_sel   (match_sel),
    .cm_mode     (cm_mode),
    .background  (background)
  );

  cam_bist_engine #(.entries(entries), .dwidth(dwidth)) u_engine (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .start_pulse (start_pulse),
    .match_sel   (match_sel),
    .cm_mode     (cm_mode),
    .background  (background),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .busy        (busy),
    .port        (cam_bus.engine)
  );

  cam_array #(.entries(entries), .dwidth(dwidth)) u_array (
    .bist_clk (bist_clk),
    .rst_n    (rst_n),
    .port     (cam_bus.array)
  );

  cam_bist_outhandler #(.entries(entries), .dwidth(dwidth)) u_outhandler (
    .bist_clk  (bist_clk),
    .rst_n     (rst_n),
    .port      (cam_bus.monitor),
    .match_sel (match_sel),
    .cm_mode   (cm_mode),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_addr  (res_addr),
    .res_data  (res_data)
  );

endmodule

`default_nettype wire

/* hw/cam_bist_outhandler.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_outhandler #(
  parameter int entries = cam_bist_pkg::cam_entries,
  parameter int dwidth  = cam_bist_pkg::cam_dwidth
) (
  input  wire logic                                bist_clk,
  input  wire logic                                rst_n,
  cam_port_if.monitor                              port,
  input  wire cam_bist_pkg::match_sel_t            match_sel,
  input  wire logic                                cm_mode,
  output logic                                     res_valid,
  input  wire logic                                res_ready,
  output logic [cam_bist_pkg::cam_awidth-1:0]      res_addr,
  output logic [dwidth-1:0]                        res_data
);

  localparam int awidth = cam_bist_pkg::cam_awidth;
  localparam int depth  = cam_bist_pkg::res_depth;
  localparam int pw     = $clog2(depth);
  localparam int folds  = (entries + dwidth - 1) / dwidth;

  // Request side delayed to line up with the array response
  logic                     valid_d1, valid_d2;
  logic [awidth-1:0]        addr_d1, addr_d2;
  cam_bist_pkg::match_sel_t sel_d1, sel_d2;
  logic                     mode_d1, mode_d2;

  logic [entries-1:0] one_hot;
  logic [entries-1:0] expected;
  logic [entries-1:0] mismatch;
  logic [dwidth-1:0]  folded;
  logic [dwidth-1:0]  sel_word;

  // Result FIFO with a power-of-two depth
  logic [awidth-1:0] q_addr [depth];
  logic [dwidth-1:0] q_data [depth];
  logic [pw-1:0]     wr_ptr, rd_ptr;
  logic [pw:0]       count;
  logic              push, pop;

  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d1 <= 1'b0;
      valid_d2 <= 1'b0;
    end else begin
      valid_d1 <= port.cmp_en | port.rd_en;
      valid_d2 <= valid_d1;
    end
  end

  always_ff @(posedge bist_clk) begin
    addr_d1 <= port.rd_addr;
    addr_d2 <= addr_d1;
    sel_d1  <= match_sel;
    sel_d2  <= sel_d1;
    mode_d1 <= cm_mode;
    mode_d2 <= mode_d1;
  end

  // ==========================================================================
  // Expected match vector and comparator
  // ==========================================================================

  assign one_hot = {{(entries-1){1'b0}}, 1'b1} << addr_d2;

  always_comb begin
    unique case (sel_d2)
      cam_bist_pkg::algo_all_match:       expected = '1;
      cam_bist_pkg::algo_single_match:    expected = one_hot;
      cam_bist_pkg::algo_single_mismatch: expected = ~one_hot;
      cam_bist_pkg::algo_all_mismatch:    expected = '0;
      default:                            expected = '0;
    endcase
  end

  // Any set bit is a faulty match line
  assign mismatch = expected ^ port.match_lines;

  // ==========================================================================
  // Compactor
  // ==========================================================================

  if (dwidth < entries) begin : g_fold
    // Bit i ORs every match line i + k*dwidth
    for (genvar i = 0; i < dwidth; i++) begin : g_bit
      logic [folds-1:0] grp;
      for (genvar k = 0; k < folds; k++) begin : g_grp
        if (i + k * dwidth < entries) begin : g_in
          assign grp[k] = mismatch[i + k * dwidth];
        end else begin : g_pad
          assign grp[k] = 1'b0;
        end
      end
      assign folded[i] = |grp;
    end
  end else if (dwidth == entries) begin : g_equal
    assign folded = mismatch;
  end else begin : g_expand
    // Match lines in the upper bits over a zero fill
    assign folded = {mismatch, {(dwidth-entries){1'b0}}};
  end

  // Mode mux between compacted compare result and raw read data
  assign sel_word = mode_d2 ? folded : port.rd_data;

  // ==========================================================================
  // First-word fall-through result FIFO
  // ==========================================================================

  assign push      = valid_d2;
  assign pop       = res_valid & res_ready;
  assign res_valid = (count != '0);
  assign res_addr  = q_addr[rd_ptr];
  assign res_data  = q_data[rd_ptr];

  always_ff @(posedge bist_clk) begin
    if (push) begin
      q_addr[wr_ptr] <= addr_d2;
      q_data[wr_ptr] <= sel_word;
    end
  end

  // Engine credits keep push from hitting a full FIFO
  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (pw+1)'(push) - (pw+1)'(pop);
    end
  end

endmodule

`default_nettype wire

/* hw/cam_bist_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_engine #(
  parameter int entries = cam_bist_pkg::cam_entries,
  parameter int dwidth  = cam_bist_pkg::cam_dwidth
) (
  input  wire logic                     bist_clk,
  input  wire logic                     rst_n,
  input  wire logic                     start_pulse,
  input  wire cam_bist_pkg::match_sel_t match_sel,
  input  wire logic                     cm_mode,
  input  wire logic [dwidth-1:0]        background,
  input  wire logic                     res_valid,
  input  wire logic                     res_ready,
  output logic                          busy,
  cam_port_if.engine                    port
);

  localparam int awidth = cam_bist_pkg::cam_awidth;
  localparam int crw    = $clog2(cam_bist_pkg::res_depth + 1);
  localparam logic [awidth-1:0] last_addr = awidth'(entries - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_step,
    st_drain
  } state_t;

  state_t            state;
  logic [awidth-1:0] addr;
  // Single mismatch sub-step 0 corrupts, 1 compares and 2 restores
  logic [1:0]        sub;
  logic [awidth-1:0] res_cnt;
  logic [crw-1:0]    credits;

  logic              have_credit;
  logic              issue;
  logic              advance;
  logic              ret;
  logic              alg10;
  logic [dwidth-1:0] uniq_val;

  assign busy        = (state != st_idle);
  assign have_credit = (credits != '0);
  assign ret         = res_valid & res_ready;
  assign alg10       = cm_mode && (match_sel == cam_bist_pkg::algo_single_mismatch);

  // Unique content of entry addr for the single match algorithm
  assign uniq_val = {background[dwidth-1:awidth], addr};

  // ==========================================================================
  // Request generation
  // ==========================================================================

  always_comb begin
    port.wr_en   = 1'b0;
    port.wr_addr = addr;
    port.wr_data = background;
    port.cmp_en  = 1'b0;
    port.cmp_key = background;
    port.rd_en   = 1'b0;
    port.rd_addr = addr;
    case (state)
      st_fill: begin
        port.wr_en = 1'b1;
        if (match_sel == cam_bist_pkg::algo_single_match) begin
          port.wr_data = uniq_val;
        end
      end
      st_step: begin
        if (alg10) begin
          // Corrupt, compare background, then restore
          case (sub)
            2'd0: begin
              port.wr_en   = 1'b1;
              port.wr_data = ~background;
            end
            2'd1: port.cmp_en = have_credit;
            default: port.wr_en = 1'b1;
          endcase
        end else if (cm_mode) begin
          port.cmp_en = have_credit;
          case (match_sel)
            cam_bist_pkg::algo_single_match: port.cmp_key = uniq_val;
            cam_bist_pkg::algo_all_mismatch: port.cmp_key = ~background;
            default:                         port.cmp_key = background;
          endcase
        end else begin
          // Normal mode reads the entry back
          port.rd_en = have_credit;
        end
      end
      default: ;
    endcase
  end

  assign issue   = port.cmp_en | port.rd_en;
  assign advance = alg10 ? (sub == 2'd2) : issue;

  // ==========================================================================
  // Sequencer, credit and result counters
  // ==========================================================================

  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      addr    <= '0;
      sub     <= '0;
      res_cnt <= '0;
      credits <= crw'(cam_bist_pkg::res_depth);
    end else begin
      // One credit out per issue and one back per result taken
      credits <= credits - crw'(issue) + crw'(ret);
      if (ret) begin
        res_cnt <= res_cnt + 1'b1;
      end
      case (state)
        st_idle: begin
          if (start_pulse) begin
            state   <= st_fill;
            addr    <= '0;
            sub     <= '0;
            res_cnt <= '0;
          end
        end
        st_fill: begin
          addr <= addr + 1'b1;
          if (addr == last_addr) begin
            state <= st_step;
            addr  <= '0;
          end
        end
        st_step: begin
          if (alg10) begin
            case (sub)
              2'd0:    sub <= 2'd1;
              2'd1:    sub <= issue ? 2'd2 : 2'd1;
              default: sub <= 2'd0;
            endcase
          end
          if (advance) begin
            addr <= addr + 1'b1;
            if (addr == last_addr) begin
              state <= st_drain;
            end
          end
        end
        st_drain: begin
          // Last handshake ends the run
          if (ret && (res_cnt == last_addr)) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/cam_bist_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_regs #(
  parameter int dwidth = cam_bist_pkg::cam_dwidth
) (
  input  wire logic                     bist_clk,
  input  wire logic                     rst_n,
  input  wire logic                     cfg_valid,
  output logic                          cfg_ready,
  input  wire logic [15:0]              cfg_word,
  input  wire logic                     busy,
  output logic                          start_pulse,
  output cam_bist_pkg::match_sel_t      match_sel,
  output logic                          cm_mode,
  output logic [dwidth-1:0]             background
);

  // Host word view, bit 15 is padding
  cam_bist_pkg::cfg_word_u word;
  logic                    accept;
  logic                    is_bg;

  assign word   = cfg_word[14:0];
  assign is_bg  = word.ctrl.kind;

  // No words during a run or in the cycle before busy rises
  assign cfg_ready = ~busy & ~start_pulse;
  assign accept    = cfg_valid & cfg_ready;

  // ==========================================================================
  // Configuration registers
  // ==========================================================================

  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      match_sel   <= cam_bist_pkg::algo_all_match;
      cm_mode     <= 1'b0;
      background  <= '0;
      start_pulse <= 1'b0;
    end else begin
      // One-cycle pulse right after a control word with start set
      start_pulse <= accept & ~is_bg & word.ctrl.start;
      if (accept) begin
        if (is_bg) begin
          background <= word.bg.background;
        end else begin
          match_sel <= word.ctrl.match_sel;
          cm_mode   <= word.ctrl.cm_mode;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/cam_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_array #(
  parameter int entries = cam_bist_pkg::cam_entries,
  parameter int dwidth  = cam_bist_pkg::cam_dwidth
) (
  input  wire logic bist_clk,
  input  wire logic rst_n,
  cam_port_if.array port
);

  localparam int awidth = cam_bist_pkg::cam_awidth;

  // Storage
  logic [dwidth-1:0] mem [entries];

  // First pipeline stage
  logic [dwidth-1:0] key_q;
  logic [awidth-1:0] raddr_q;
  logic              cmp_q;
  logic              rd_q;

  // Per-entry hit from the registered key
  logic [entries-1:0] hit;

  // ==========================================================================
  // Write port
  // ==========================================================================

  always_ff @(posedge bist_clk) begin
    if (port.wr_en) begin
      mem[port.wr_addr] <= port.wr_data;
    end
  end

  // ==========================================================================
  // Compare and read pipeline
  // ==========================================================================

  // Stage 1 valid flags
  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      cmp_q <= 1'b0;
      rd_q  <= 1'b0;
    end else begin
      cmp_q <= port.cmp_en;
      rd_q  <= port.rd_en;
    end
  end

  // All entries compared in parallel against the stage 1 key
  always_comb begin
    for (int e = 0; e < entries; e++) begin
      hit[e] = (mem[e] == key_q);
    end
  end

  // Stage 1 captures the request, stage 2 the response
  always_ff @(posedge bist_clk) begin
    if (port.cmp_en) begin
      key_q <= port.cmp_key;
    end
    if (port.rd_en) begin
      raddr_q <= port.rd_addr;
    end
    if (cmp_q) begin
      port.match_lines <= hit;
    end
    if (rd_q) begin
      port.rd_data <= mem[raddr_q];
    end
  end

endmodule

`default_nettype wire

/* hw/cam_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cam_port_if #(
  parameter int entries = cam_bist_pkg::cam_entries,
  parameter int dwidth  = cam_bist_pkg::cam_dwidth
);

  // Write port, takes effect at the clock edge
  logic                                wr_en;
  logic [cam_bist_pkg::cam_awidth-1:0] wr_addr;
  logic [dwidth-1:0]                   wr_data;

  // Compare port
  logic              cmp_en;
  logic [dwidth-1:0] cmp_key;

  // Read port, rd_addr also tags compares with the step address
  logic                                rd_en;
  logic [cam_bist_pkg::cam_awidth-1:0] rd_addr;

  // Responses, two cycles after the request
  logic [entries-1:0] match_lines;
  logic [dwidth-1:0]  rd_data;

  // BIST engine side
  modport engine (
    output wr_en, wr_addr, wr_data,
    output cmp_en, cmp_key,
    output rd_en, rd_addr
  );

  // CAM macro side
  modport array (
    input  wr_en, wr_addr, wr_data,
    input  cmp_en, cmp_key,
    input  rd_en, rd_addr,
    output match_lines, rd_data
  );

  // Output handler taps requests and responses
  modport monitor (
    input cmp_en, rd_en, rd_addr,
    input match_lines, rd_data
  );

endinterface

`default_nettype wire

/* hw/cam_bist_pkg.sv */
`default_nettype none

package cam_bist_pkg;

  // ==========================================================================
  // Array geometry
  // ==========================================================================

  // Default CAM depth and word width
  localparam int cam_entries = 16;
  localparam int cam_dwidth  = 8;

  // Address width covers cam_entries
  localparam int cam_awidth  = 4;

  // Result FIFO depth, also the initial engine credit count
  localparam int res_depth   = 4;

  // Compare algorithm, also selects the expected match pattern
  typedef enum logic [1:0] {
    algo_all_match       = 2'b00,
    algo_single_match    = 2'b01,
    algo_single_mismatch = 2'b10,
    algo_all_mismatch    = 2'b11
  } match_sel_t;

  // ==========================================================================
  // Host configuration word
  // ==========================================================================

  // Host word bit 15 is padding, bits 14:0 hold the union below
  // Kind bit 14 is 0 for a control write
  typedef struct packed {
    logic       kind;
    logic       start;
    logic       cm_mode;
    match_sel_t match_sel;
    logic [9:0] spare;
  } cfg_ctrl_t;

  // Kind bit 14 is 1 for a background write
  typedef struct packed {
    logic                  kind;
    logic [5:0]            spare;
    logic [cam_dwidth-1:0] background;
  } cfg_bg_t;

  // Same 15 bits seen as control or as background
  typedef union packed {
    cfg_ctrl_t ctrl;
    cfg_bg_t   bg;
  } cfg_word_u;

endpackage

`default_nettype wire
